// ==== logic/lsu_pkg.sv ====
package lsu_pkg;

    // data and address width
    localparam int xlen = 32;

    // one strobe bit per byte
    localparam int mask_bits = 4;

    // reorder buffer tag width
    localparam int rob_id_bits = 4;

    // physical register tag width
    localparam int pr_bits = 6;

    // rv32i load funct3 field
    // bit 2 set means zero extension
    typedef enum logic [2:0] {
        load_f3_lb  = 3'b000,
        load_f3_lh  = 3'b001,
        load_f3_lw  = 3'b010,
        load_f3_lbu = 3'b100,
        load_f3_lhu = 3'b101
    } load_funct3_e;

    // a loaded word, picked apart by byte lane or by half lane
    // lane 0 is the least significant one, as on the cache bus
    typedef union packed {
        logic [xlen-1:0]  word;
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
    } load_word_u;

endpackage : lsu_pkg

// ==== logic/store_queue.sv ====
`timescale 1ns/1ps

module store_queue #(
    parameter int sq_depth = 4
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          enq,
    input  logic [lsu_pkg::xlen-1:0]      din_addr,
    input  logic [lsu_pkg::mask_bits-1:0] din_mask,
    input  logic [lsu_pkg::xlen-1:0]      din_wdata,
    input  logic                          deq,
    output logic [lsu_pkg::xlen-1:0]      head_addr,
    output logic [lsu_pkg::mask_bits-1:0] head_mask,
    output logic [lsu_pkg::xlen-1:0]      head_wdata,
    output logic                          full,
    output logic                          nonempty,
    output logic [lsu_pkg::xlen-1:0]      slot_addr  [sq_depth],
    output logic [lsu_pkg::mask_bits-1:0] slot_mask  [sq_depth],
    output logic [lsu_pkg::xlen-1:0]      slot_wdata [sq_depth],
    output logic [sq_depth-1:0]           slot_valid,
    output logic [$clog2(sq_depth)-1:0]   head_ptr
);
    import lsu_pkg::*;

    localparam int ptr_bits = $clog2(sq_depth);

    // entry storage, written at the tail
    logic [xlen-1:0]      mem_addr  [sq_depth];
    logic [mask_bits-1:0] mem_mask  [sq_depth];
    logic [xlen-1:0]      mem_wdata [sq_depth];

    logic [ptr_bits-1:0]  head_q;
    logic [ptr_bits-1:0]  tail_q;
    logic [ptr_bits:0]    count;
    logic [sq_depth-1:0]  valid_q;

    // pointers wrap by truncation, depth is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            head_q  <= '0;
            tail_q  <= '0;
            count   <= '0;
            valid_q <= '0;
        end else begin
            if (enq) begin
                tail_q          <= tail_q + 1'b1;
                valid_q[tail_q] <= 1'b1;
            end
            if (deq) begin
                head_q          <= head_q + 1'b1;
                valid_q[head_q] <= 1'b0;
            end
            // simultaneous push and pop leaves the count alone
            case ({enq, deq})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (enq) begin
            mem_addr[tail_q]  <= din_addr;
            mem_mask[tail_q]  <= din_mask;
            mem_wdata[tail_q] <= din_wdata;
        end
    end

    assign full     = (count == (ptr_bits + 1)'(sq_depth));
    assign nonempty = (count != '0);

    // oldest entry, next to drain
    assign head_addr  = mem_addr[head_q];
    assign head_mask  = mem_mask[head_q];
    assign head_wdata = mem_wdata[head_q];
    assign head_ptr   = head_q;

    // whole queue visible to the forwarding scan
    assign slot_addr  = mem_addr;
    assign slot_mask  = mem_mask;
    assign slot_wdata = mem_wdata;
    assign slot_valid = valid_q;

    // producer must check full before pushing
    a_no_enq_full: assert property (@(posedge clk) disable iff (rst) enq |-> !full);

    // pops only come from a completed drain
    a_no_deq_empty: assert property (@(posedge clk) disable iff (rst) deq |-> nonempty);

endmodule : store_queue

// ==== logic/store_forward.sv ====
`timescale 1ns/1ps

module store_forward #(
    parameter int sq_depth = 4
) (
    input  logic [lsu_pkg::xlen-1:0]      slot_addr  [sq_depth],
    input  logic [lsu_pkg::mask_bits-1:0] slot_mask  [sq_depth],
    input  logic [lsu_pkg::xlen-1:0]      slot_wdata [sq_depth],
    input  logic [sq_depth-1:0]           slot_valid,
    input  logic [$clog2(sq_depth)-1:0]   head_ptr,
    input  logic [lsu_pkg::xlen-1:0]      load_addr,
    input  logic [lsu_pkg::mask_bits-1:0] load_mask,
    output logic [lsu_pkg::mask_bits-1:0] fwd_mask,
    output logic [lsu_pkg::xlen-1:0]      fwd_data,
    output logic                          fwd_full
);
    import lsu_pkg::*;

    localparam int ptr_bits = $clog2(sq_depth);

    // slot index in age order, 0 is the oldest
    logic [ptr_bits-1:0]  idx;

    // bytes this slot supplies to the load
    logic [mask_bits-1:0] hit;

    // walk from head to tail so later stores overwrite earlier ones
    always_comb begin
        fwd_mask = '0;
        fwd_data = '0;
        idx      = '0;
        hit      = '0;
        for (int i = 0; i < sq_depth; i++) begin
            idx = head_ptr + ptr_bits'(i);
            hit = '0;
            // word match only, store addresses are already aligned
            if (slot_valid[idx] && (slot_addr[idx][xlen-1:2] == load_addr[xlen-1:2])) begin
                hit = load_mask & slot_mask[idx];
            end
            fwd_mask = fwd_mask | hit;
            for (int b = 0; b < mask_bits; b++) begin
                if (hit[b]) begin
                    fwd_data[8*b +: 8] = slot_wdata[idx][8*b +: 8];
                end
            end
        end
    end

    // every requested byte sits in the queue, no cache access needed
    assign fwd_full = (fwd_mask == load_mask);

endmodule : store_forward

// ==== logic/dcache_arbiter.sv ====
`timescale 1ns/1ps

module dcache_arbiter (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          rob_flush,
    input  logic                          load_req,
    input  logic [lsu_pkg::xlen-1:0]      load_addr,
    input  logic [lsu_pkg::mask_bits-1:0] load_mask,
    input  logic                          sq_nonempty,
    input  logic [lsu_pkg::xlen-1:0]      sq_head_addr,
    input  logic [lsu_pkg::mask_bits-1:0] sq_head_mask,
    input  logic [lsu_pkg::xlen-1:0]      sq_head_wdata,
    output logic [lsu_pkg::xlen-1:0]      dcache_addr,
    output logic [lsu_pkg::mask_bits-1:0] dcache_rmask,
    output logic [lsu_pkg::mask_bits-1:0] dcache_wmask,
    output logic [lsu_pkg::xlen-1:0]      dcache_wdata,
    input  logic                          dcache_resp,
    output logic                          load_resp,
    output logic                          sq_pop
);
    import lsu_pkg::*;

    // kind of the transaction in flight
    logic load_out;
    logic store_out;

    // response of the transaction in flight is stale
    logic invalidate;

    logic idle;
    logic issue_load;
    logic issue_store;

    assign idle = !load_out && !store_out;

    // loads first, drains only fill otherwise idle cycles
    assign issue_load  = idle && load_req;
    assign issue_store = idle && !load_req && sq_nonempty;

    always_ff @(posedge clk) begin
        if (rst) begin
            load_out  <= 1'b0;
            store_out <= 1'b0;
        end else if (issue_load) begin
            load_out <= 1'b1;
        end else if (issue_store) begin
            store_out <= 1'b1;
        end else if (dcache_resp) begin
            // transaction done, stale or not
            load_out  <= 1'b0;
            store_out <= 1'b0;
        end
    end

    // flush may land before or during the request
    // the first response after it is dropped
    always_ff @(posedge clk) begin
        if (rst) begin
            invalidate <= 1'b0;
        end else if (rob_flush) begin
            invalidate <= 1'b1;
        end else if (dcache_resp) begin
            invalidate <= 1'b0;
        end
    end

    // request mux, masks stay zero unless a request goes out
    always_comb begin
        dcache_addr  = sq_head_addr;
        dcache_wdata = sq_head_wdata;
        dcache_rmask = '0;
        dcache_wmask = '0;
        if (issue_load) begin
            dcache_addr  = {load_addr[xlen-1:2], 2'b00};
            dcache_rmask = load_mask;
        end else if (issue_store) begin
            dcache_wmask = sq_head_mask;
        end
    end

    // qualified completions
    assign load_resp = load_out && dcache_resp && !invalidate;

    // stale drain stays queued and goes out again
    assign sq_pop = store_out && dcache_resp && !invalidate;

    a_one_kind: assert property (@(posedge clk) disable iff (rst)
        !((|dcache_rmask) && (|dcache_wmask)));

    // single outstanding transaction toward the cache
    a_one_outstanding: assert property (@(posedge clk) disable iff (rst)
        ((|dcache_rmask) || (|dcache_wmask)) |-> !(load_out || store_out));

endmodule : dcache_arbiter

// ==== logic/load_align.sv ====
`timescale 1ns/1ps

module load_align (
    input  logic [lsu_pkg::xlen-1:0]      cache_rdata,
    input  logic [lsu_pkg::xlen-1:0]      fwd_data,
    input  logic [lsu_pkg::mask_bits-1:0] fwd_mask,
    input  logic                          use_cache,
    input  logic [1:0]                    addr_low,
    input  lsu_pkg::load_funct3_e         funct3,
    output logic [lsu_pkg::xlen-1:0]      result
);
    import lsu_pkg::*;

    load_word_u merged;
    logic [7:0]  lane_byte;
    logic [15:0] lane_half;

    // newer store bytes take priority over cache bytes
    always_comb begin
        merged.word = use_cache ? cache_rdata : fwd_data;
        if (use_cache) begin
            for (int b = 0; b < mask_bits; b++) begin
                if (fwd_mask[b]) begin
                    merged.bytes[b] = fwd_data[8*b +: 8];
                end
            end
        end
    end

    // lane pick, half loads use bit 1 only
    assign lane_byte = merged.bytes[addr_low];
    assign lane_half = merged.halves[addr_low[1]];

    always_comb begin
        case (funct3)
            load_f3_lb:  result = {{(xlen-8){lane_byte[7]}}, lane_byte};
            load_f3_lbu: result = {{(xlen-8){1'b0}}, lane_byte};
            load_f3_lh:  result = {{(xlen-16){lane_half[15]}}, lane_half};
            load_f3_lhu: result = {{(xlen-16){1'b0}}, lane_half};
            default:     result = merged.word;
        endcase
    end

endmodule : load_align

// ==== logic/store_buffer.sv ====
`timescale 1ns/1ps

module store_buffer #(
    parameter int sq_depth = 4
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            rob_flush,
    input  logic                            lsq_valid,
    input  logic                            lsq_ready,
    input  logic                            lsq_is_load,
    input  logic [lsu_pkg::xlen-1:0]        lsq_addr,
    input  logic [lsu_pkg::mask_bits-1:0]   lsq_mask,
    input  logic [lsu_pkg::xlen-1:0]        lsq_wdata,
    input  lsu_pkg::load_funct3_e           lsq_funct3,
    input  logic [lsu_pkg::rob_id_bits-1:0] lsq_rob_id,
    input  logic [lsu_pkg::pr_bits-1:0]     lsq_pr_dest,
    input  logic [lsu_pkg::rob_id_bits-1:0] rob_head_id,
    output logic                            lsq_dequeue,
    output logic [lsu_pkg::xlen-1:0]        dcache_addr,
    output logic [lsu_pkg::mask_bits-1:0]   dcache_rmask,
    output logic [lsu_pkg::mask_bits-1:0]   dcache_wmask,
    output logic [lsu_pkg::xlen-1:0]        dcache_wdata,
    input  logic [lsu_pkg::xlen-1:0]        dcache_rdata,
    input  logic                            dcache_resp,
    output logic                            cdb_valid,
    output logic [lsu_pkg::rob_id_bits-1:0] cdb_rob_id,
    output logic [lsu_pkg::pr_bits-1:0]     cdb_pr_dest,
    output logic [lsu_pkg::xlen-1:0]        cdb_result,
    output logic                            store_done
);
    import lsu_pkg::*;

    localparam int ptr_bits = $clog2(sq_depth);

    // store queue side
    logic                 sq_full;
    logic                 sq_nonempty;
    logic                 sq_pop;
    logic [xlen-1:0]      sq_head_addr;
    logic [mask_bits-1:0] sq_head_mask;
    logic [xlen-1:0]      sq_head_wdata;
    logic [xlen-1:0]      slot_addr  [sq_depth];
    logic [mask_bits-1:0] slot_mask  [sq_depth];
    logic [xlen-1:0]      slot_wdata [sq_depth];
    logic [sq_depth-1:0]  slot_valid;
    logic [ptr_bits-1:0]  head_ptr;

    // forwarding result
    logic [mask_bits-1:0] fwd_mask;
    logic [xlen-1:0]      fwd_data;
    logic                 fwd_full;

    logic head_ok;
    logic store_accept;
    logic load_head;
    logic load_fwd;
    logic load_req;
    logic load_resp;

    // head entry usable, operands resolved
    assign head_ok = lsq_valid && lsq_ready;

    // stores commit only as the oldest rob entry
    assign store_accept = head_ok && !lsq_is_load && (lsq_rob_id == rob_head_id) && !sq_full;

    assign load_head = head_ok && lsq_is_load;
    assign load_fwd  = load_head && fwd_full;
    assign load_req  = load_head && !fwd_full;

    store_queue #(
        .sq_depth(sq_depth)
    ) i_store_queue (
        .clk        (clk),
        .rst        (rst),
        .enq        (store_accept),
        .din_addr   ({lsq_addr[xlen-1:2], 2'b00}),
        .din_mask   (lsq_mask),
        .din_wdata  (lsq_wdata),
        .deq        (sq_pop),
        .head_addr  (sq_head_addr),
        .head_mask  (sq_head_mask),
        .head_wdata (sq_head_wdata),
        .full       (sq_full),
        .nonempty   (sq_nonempty),
        .slot_addr  (slot_addr),
        .slot_mask  (slot_mask),
        .slot_wdata (slot_wdata),
        .slot_valid (slot_valid),
        .head_ptr   (head_ptr)
    );

    store_forward #(
        .sq_depth(sq_depth)
    ) i_store_forward (
        .slot_addr  (slot_addr),
        .slot_mask  (slot_mask),
        .slot_wdata (slot_wdata),
        .slot_valid (slot_valid),
        .head_ptr   (head_ptr),
        .load_addr  (lsq_addr),
        .load_mask  (lsq_mask),
        .fwd_mask   (fwd_mask),
        .fwd_data   (fwd_data),
        .fwd_full   (fwd_full)
    );

    dcache_arbiter i_dcache_arbiter (
        .clk           (clk),
        .rst           (rst),
        .rob_flush     (rob_flush),
        .load_req      (load_req),
        .load_addr     (lsq_addr),
        .load_mask     (lsq_mask),
        .sq_nonempty   (sq_nonempty),
        .sq_head_addr  (sq_head_addr),
        .sq_head_mask  (sq_head_mask),
        .sq_head_wdata (sq_head_wdata),
        .dcache_addr   (dcache_addr),
        .dcache_rmask  (dcache_rmask),
        .dcache_wmask  (dcache_wmask),
        .dcache_wdata  (dcache_wdata),
        .dcache_resp   (dcache_resp),
        .load_resp     (load_resp),
        .sq_pop        (sq_pop)
    );

    // cache word only matters when forwarding was partial
    load_align i_load_align (
        .cache_rdata (dcache_rdata),
        .fwd_data    (fwd_data),
        .fwd_mask    (fwd_mask),
        .use_cache   (!fwd_full),
        .addr_low    (lsq_addr[1:0]),
        .funct3      (lsq_funct3),
        .result      (cdb_result)
    );

    // loads finish from the queue at once or on the cache response
    assign cdb_valid   = load_fwd || load_resp;
    assign cdb_rob_id  = lsq_rob_id;
    assign cdb_pr_dest = lsq_pr_dest;

    assign store_done  = store_accept;
    assign lsq_dequeue = store_accept || cdb_valid;

    // load response must find its load still at the lsq head
    a_deq_valid: assert property (@(posedge clk) disable iff (rst) lsq_dequeue |-> lsq_valid);

endmodule : store_buffer

// ==== verif/tb_store_buffer.sv ====
`timescale 1ns/1ps

module tb_store_buffer;
    import lsu_pkg::*;

    localparam int max_rows = 64;
    localparam int k_store  = 0;
    localparam int k_load   = 1;
    // load presented together with a one-cycle rob_flush
    localparam int k_flush  = 2;

    logic                   clk = 1'b0;
    logic                   rst;
    logic                   rob_flush;
    logic                   lsq_valid;
    logic                   lsq_ready;
    logic                   lsq_is_load;
    logic [xlen-1:0]        lsq_addr;
    logic [mask_bits-1:0]   lsq_mask;
    logic [xlen-1:0]        lsq_wdata;
    load_funct3_e           lsq_funct3;
    logic [rob_id_bits-1:0] lsq_rob_id;
    logic [pr_bits-1:0]     lsq_pr_dest;
    logic [rob_id_bits-1:0] rob_head_id;
    logic                   lsq_dequeue;
    logic [xlen-1:0]        dcache_addr;
    logic [mask_bits-1:0]   dcache_rmask;
    logic [mask_bits-1:0]   dcache_wmask;
    logic [xlen-1:0]        dcache_wdata;
    logic [xlen-1:0]        dcache_rdata;
    logic                   dcache_resp;
    logic                   cdb_valid;
    logic [rob_id_bits-1:0] cdb_rob_id;
    logic [pr_bits-1:0]     cdb_pr_dest;
    logic [xlen-1:0]        cdb_result;
    logic                   store_done;

    // operation table, due is the expected finishing cycle or -1
    int                   row_kind  [max_rows];
    logic [xlen-1:0]      row_addr  [max_rows];
    logic [mask_bits-1:0] row_mask  [max_rows];
    logic [xlen-1:0]      row_wdata [max_rows];
    logic [2:0]           row_f3    [max_rows];
    int                   row_stall [max_rows];
    int                   row_due   [max_rows];
    logic [xlen-1:0]      row_exp   [max_rows];
    int                   n_rows;
    logic                 table_ready;

    // cache model and reference image, word indexed by addr[7:2]
    logic [xlen-1:0]      mem_model [64];
    logic [xlen-1:0]      ref_mem   [64];
    logic                 model_busy;
    logic                 req_write;
    logic [xlen-1:0]      req_addr;
    logic [mask_bits-1:0] req_mask;
    logic [xlen-1:0]      req_wdata;
    int                   wait_cnt;
    integer               seed;

    int errors;
    int model_errs;
    int passed;
    int full_stalls;

    store_buffer #(.sq_depth(4)) i_dut (.*);

    always #4 clk = ~clk;

    // every byte differs with the word address
    function automatic logic [xlen-1:0] fill_word(input int idx);
        logic [7:0] a;
        a = 8'(idx * 4);
        return {a ^ 8'ha5, a + 8'h3c, ~a, a};
    endfunction

    function automatic logic [mask_bits-1:0] load_mask_for(input logic [2:0] f3,
                                                          input logic [xlen-1:0] addr);
        case (f3)
            load_f3_lb, load_f3_lbu: return 4'b0001 << addr[1:0];
            load_f3_lh, load_f3_lhu: return 4'b0011 << {addr[1], 1'b0};
            default:                 return 4'hf;
        endcase
    endfunction

    // lane pick and extension straight from the rv32i load rules
    function automatic logic [xlen-1:0] expect_load(input logic [xlen-1:0] word,
                                                    input logic [1:0] off,
                                                    input logic [2:0] f3);
        load_word_u w;
        w.word = word;
        case (f3)
            load_f3_lb:  return 32'($signed(w.bytes[off]));
            load_f3_lbu: return 32'(w.bytes[off]);
            load_f3_lh:  return 32'($signed(w.halves[off[1]]));
            load_f3_lhu: return 32'(w.halves[off[1]]);
            default:     return w.word;
        endcase
    endfunction

    function automatic string kind_name(input int k);
        return (k == k_store) ? "store" : ((k == k_load) ? "load" : "flush+load");
    endfunction

    task automatic add_row(input int kind, input logic [xlen-1:0] addr,
                           input logic [mask_bits-1:0] mask, input logic [xlen-1:0] wdata,
                           input logic [2:0] f3, input int stall, input int due);
        row_kind[n_rows]  = kind;
        row_addr[n_rows]  = addr;
        row_mask[n_rows]  = mask;
        row_wdata[n_rows] = wdata;
        row_f3[n_rows]    = f3;
        row_stall[n_rows] = stall;
        row_due[n_rows]   = due;
        n_rows++;
    endtask

    task automatic add_load(input logic [xlen-1:0] addr, input logic [2:0] f3, input int due);
        add_row(k_load, addr, load_mask_for(f3, addr), '0, f3, 0, due);
    endtask

    task automatic build_table();
        n_rows = 0;
        // store at the rob head, then one held three cycles off the head
        add_row(k_store, 32'h40, 4'hf, 32'h1122_3344, load_f3_lw, 0, 0);
        add_row(k_store, 32'h44, 4'hf, 32'h5566_7788, load_f3_lw, 3, 3);
        // nothing queued for these words
        add_load(32'h80, load_f3_lw, -1);
        add_load(32'h84, load_f3_lw, -1);
        // full cover, newer store owns the middle bytes
        add_row(k_store, 32'h10, 4'hf, 32'ha1b2_c3d4, load_f3_lw, 0, -1);
        add_row(k_store, 32'h10, 4'b0110, 32'h00ee_ff00, load_f3_lw, 0, -1);
        add_load(32'h10, load_f3_lw, 0);
        // partial cover, rest of the word from memory
        add_row(k_store, 32'h20, 4'b0011, 32'h0000_beef, load_f3_lw, 0, -1);
        add_load(32'h20, load_f3_lw, -1);
        add_row(k_store, 32'h24, 4'b1000, 32'h9c00_0000, load_f3_lw, 0, -1);
        add_load(32'h26, load_f3_lhu, -1);
        // sign bits set and clear in every lane
        add_row(k_store, 32'h30, 4'hf, 32'h807f_c35a, load_f3_lw, 0, -1);
        add_row(k_store, 32'h34, 4'hf, 32'h7ff0_0f81, load_f3_lw, 0, -1);
        for (int w = 0; w < 2; w++) begin
            for (int b = 0; b < 4; b++) begin
                add_load(32'h30 + 32'(4 * w + b), load_f3_lb, -1);
                add_load(32'h30 + 32'(4 * w + b), load_f3_lbu, -1);
            end
            for (int h = 0; h < 2; h++) begin
                add_load(32'h30 + 32'(4 * w + 2 * h), load_f3_lh, -1);
                add_load(32'h30 + 32'(4 * w + 2 * h), load_f3_lhu, -1);
            end
        end
        // burst outruns the drain rate and fills the queue
        for (int i = 0; i < 8; i++) begin
            add_row(k_store, 32'h60 + 32'(4 * i), 4'hf, 32'hc0de_0000 | 32'(i * 257),
                    load_f3_lw, 0, -1);
        end
        add_load(32'h60, load_f3_lw, -1);
        add_load(32'h7c, load_f3_lw, -1);
        add_row(k_flush, 32'h64, 4'hf, '0, load_f3_lw, 0, -1);
        add_row(k_flush, 32'h35, load_mask_for(load_f3_lbu, 32'h35), '0, load_f3_lbu, 0, -1);
        add_load(32'h44, load_f3_lh, -1);
        table_ready = 1'b1;
    endtask

    // stores update the image in table order, loads read it
    task automatic compute_expected();
        for (int i = 0; i < 64; i++) begin
            ref_mem[i] = fill_word(i);
        end
        for (int r = 0; r < n_rows; r++) begin
            row_exp[r] = '0;
            if (row_kind[r] == k_store) begin
                for (int b = 0; b < mask_bits; b++) begin
                    if (row_mask[r][b]) begin
                        ref_mem[row_addr[r][7:2]][8*b +: 8] = row_wdata[r][8*b +: 8];
                    end
                end
            end else begin
                row_exp[r] = expect_load(ref_mem[row_addr[r][7:2]], row_addr[r][1:0], row_f3[r]);
            end
        end
    endtask

    // idle once a few cycles pass with no request and no response
    task automatic wait_cache_idle();
        int quiet;
        quiet = 0;
        @(posedge clk);
        #1;
        lsq_valid = 1'b0;
        while (quiet < 3) begin
            @(negedge clk);
            if (model_busy || dcache_resp || (|dcache_rmask) || (|dcache_wmask)) begin
                quiet = 0;
            end else begin
                quiet++;
            end
        end
    endtask

    task automatic apply_row(input int r);
        int   cycles;
        int   stall_left;
        int   resp_seen;
        int   row_errs;
        logic done;
        logic is_store;
        cycles     = 0;
        stall_left = row_stall[r];
        resp_seen  = 0;
        row_errs   = 0;
        done       = 1'b0;
        is_store   = (row_kind[r] == k_store);
        if (row_kind[r] == k_flush) begin
            wait_cache_idle();
        end
        @(posedge clk);
        #1;
        lsq_valid   = 1'b1;
        lsq_ready   = 1'b1;
        lsq_is_load = !is_store;
        lsq_addr    = row_addr[r];
        lsq_mask    = row_mask[r];
        lsq_wdata   = row_wdata[r];
        lsq_funct3  = load_funct3_e'(row_f3[r]);
        lsq_rob_id  = rob_id_bits'(r);
        lsq_pr_dest = pr_bits'(r);
        rob_head_id = (stall_left > 0) ? rob_id_bits'(r + 1) : rob_id_bits'(r);
        rob_flush   = (row_kind[r] == k_flush);
        while (!done) begin
            @(negedge clk);
            // the response right after the flush must be dropped
            if (row_kind[r] == k_flush && dcache_resp && resp_seen == 0 && cdb_valid) begin
                $display("row %0d result broadcast for a flushed cache response", r);
                row_errs++;
            end
            if (dcache_resp) begin
                resp_seen++;
            end
            if (lsq_dequeue) begin
                done = 1'b1;
                if (is_store && rob_head_id != lsq_rob_id) begin
                    $display("row %0d store left the queue before reaching the rob head", r);
                    row_errs++;
                end
                if (store_done !== is_store) begin
                    $display("[FAIL] row %0d store_done got %h exp %h", r, store_done, is_store);
                    row_errs++;
                end
                if (cdb_valid !== !is_store) begin
                    $display("[FAIL] row %0d cdb_valid got %h exp %h", r, cdb_valid, !is_store);
                    row_errs++;
                end
                if (!is_store && cdb_rob_id !== rob_id_bits'(r)) begin
                    $display("[FAIL] row %0d cdb_rob_id got %h exp %h", r, cdb_rob_id,
                             rob_id_bits'(r));
                    row_errs++;
                end
                if (!is_store && cdb_pr_dest !== pr_bits'(r)) begin
                    $display("[FAIL] row %0d cdb_pr_dest got %h exp %h", r, cdb_pr_dest,
                             pr_bits'(r));
                    row_errs++;
                end
                if (!is_store && cdb_result !== row_exp[r]) begin
                    $display("[FAIL] row %0d cdb_result got %h exp %h", r, cdb_result, row_exp[r]);
                    row_errs++;
                end
                if (row_due[r] >= 0 && cycles != row_due[r]) begin
                    $display("row %0d finished after %0d cycles instead of %0d", r, cycles,
                             row_due[r]);
                    row_errs++;
                end
                if (row_kind[r] == k_flush && resp_seen < 2) begin
                    $display("row %0d flushed load finished without being reissued", r);
                    row_errs++;
                end
            end else if (store_done) begin
                $display("row %0d store_done raised without a dequeue", r);
                row_errs++;
            end else if (is_store && rob_head_id == lsq_rob_id) begin
                // at the head and ready, only a full queue holds it
                full_stalls++;
            end
            if (!done) begin
                cycles++;
                @(posedge clk);
                #1;
                rob_flush = 1'b0;
                if (stall_left > 0) begin
                    stall_left--;
                end
                rob_head_id = (stall_left > 0) ? rob_id_bits'(r + 1) : rob_id_bits'(r);
            end
        end
        errors += row_errs;
        if (row_errs == 0) begin
            passed++;
            $display("row %0d %s @%h ok after %0d cycles", r, kind_name(row_kind[r]),
                     row_addr[r], cycles);
        end else begin
            $display("row %0d %s @%h failed with %0d errors", r, kind_name(row_kind[r]),
                     row_addr[r], row_errs);
        end
    endtask

    // cache model, takes a request at negedge, answers 1 to 3 cycles later
    initial begin
        seed        = 32'h29460016;
        model_busy  = 1'b0;
        dcache_resp = 1'b0;
        dcache_rdata = '0;
        model_errs  = 0;
        for (int i = 0; i < 64; i++) begin
            mem_model[i] = fill_word(i);
        end
        forever begin
            @(negedge clk);
            if (!rst && ((|dcache_rmask) || (|dcache_wmask))) begin
                if (model_busy) begin
                    $display("cache request issued while a transaction was outstanding");
                    model_errs++;
                end else begin
                    model_busy = 1'b1;
                    req_write  = |dcache_wmask;
                    req_addr   = dcache_addr;
                    req_mask   = req_write ? dcache_wmask : dcache_rmask;
                    req_wdata  = dcache_wdata;
                    wait_cnt   = 1 + int'({$random(seed)} % 3);
                end
            end
            @(posedge clk);
            #1;
            dcache_resp = 1'b0;
            if (model_busy) begin
                wait_cnt--;
                if (wait_cnt == 0) begin
                    model_busy  = 1'b0;
                    dcache_resp = 1'b1;
                    if (req_write) begin
                        for (int b = 0; b < mask_bits; b++) begin
                            if (req_mask[b]) begin
                                mem_model[req_addr[7:2]][8*b +: 8] = req_wdata[8*b +: 8];
                            end
                        end
                    end else begin
                        dcache_rdata = mem_model[req_addr[7:2]];
                    end
                end
            end
        end
    end

    // budget of forty cycles per table row
    initial begin
        wait (table_ready === 1'b1);
        repeat (n_rows * 40) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not finish", n_rows * 40);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        int bad_words;
        rst         = 1'b1;
        rob_flush   = 1'b0;
        lsq_valid   = 1'b0;
        lsq_ready   = 1'b0;
        lsq_is_load = 1'b0;
        lsq_addr    = '0;
        lsq_mask    = '0;
        lsq_wdata   = '0;
        lsq_funct3  = load_f3_lw;
        lsq_rob_id  = '0;
        lsq_pr_dest = '0;
        rob_head_id = '0;
        errors      = 0;
        passed      = 0;
        full_stalls = 0;
        bad_words   = 0;
        build_table();
        compute_expected();
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int r = 0; r < n_rows; r++) begin
            apply_row(r);
        end
        // let the queue drain before looking at memory
        wait_cache_idle();
        if (full_stalls == 0) begin
            $display("store queue never held back a store at the rob head");
            errors++;
        end else begin
            passed++;
            $display("store queue back-pressure held stores for %0d cycles", full_stalls);
        end
        for (int i = 0; i < 64; i++) begin
            if (mem_model[i] !== ref_mem[i]) begin
                $display("[FAIL] mem_model[%0d] got %h exp %h", i, mem_model[i], ref_mem[i]);
                bad_words++;
            end
        end
        errors += bad_words + model_errs;
        if (bad_words == 0) begin
            passed++;
            $display("memory image matches after the drain");
        end else begin
            $display("memory image has %0d wrong words", bad_words);
        end
        $display("tests %0d, passed %0d, failed %0d", n_rows + 2, passed, n_rows + 2 - passed);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule : tb_store_buffer

// ==== files.f ====
logic/lsu_pkg.sv
logic/store_queue.sv
logic/store_forward.sv
logic/dcache_arbiter.sv
logic/load_align.sv
logic/store_buffer.sv
verif/tb_store_buffer.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the store buffer testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_store_buffer -Mdir obj_dir -o sim_store_buffer -f files.f
./obj_dir/sim_store_buffer > sim.log 2>&1
cat sim.log
if grep -q "=== FAIL ===" sim.log; then
    exit 1
fi
grep -q "=== PASS ===" sim.log
